// File: all.f
source/upload_ctrl_pkg.sv
source/msx_cfg_pkg.sv
source/upload_ifs.sv
source/ddr_arbiter.sv
source/config_sequencer.sv
source/block_loader.sv
source/layout_table.sv
source/mem_upload_top.sv
testbench/mem_upload_asserts.sv
testbench/tb_mem_upload.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run; passes only when the pass line is printed
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_upload \
        -f all.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "All checks passed" \
    && echo "Simulation passed" \
    || { echo "Simulation did not pass"; exit 1; }

// File: source/block_loader.sv
`timescale 1ns/10ps

module block_loader (
    input  logic                       clk,
    input  logic                       arst_n,
    block_job_if.loader                job,
    ddr_rd_if.client                   ddr,
    output upload_ctrl_pkg::ram_addr_t ram_addr,
    output logic                 [7:0] ram_din,
    output logic                       ram_we,
    input  logic                       ram_ready
);
    import upload_ctrl_pkg::*;
    import msx_cfg_pkg::*;

    logic                 active;
    logic                 pend;
    logic                 have;         // DDR byte waiting for RAM
    logic                 copy;
    logic [page_log2+7:0] cnt;
    ram_addr_t            base;
    ddr_addr_t            src;
    pattern_t             pattern;
    logic [8:0]           pos;
    logic [7:0]           pat_byte;

    assign pos = 9'(ram_addr - base);

    always_comb begin
        case (pattern)
            pat_ff:  pat_byte = 8'hff;
            pat_03:  pat_byte = (pos[8] != pos[1]) ? 8'hff : 8'h00;
            pat_04:  pat_byte = (pos[8] == pos[0]) ? 8'hff : 8'h00;
            pat_05:  pat_byte = pos[7] ? 8'hff : 8'h00;
            default: pat_byte = 8'h00;
        endcase
    end

    assign ram_din      = copy ? ddr.dout : pat_byte;
    assign ram_we       = active && cnt != '0 && (have || !copy) && ram_ready;
    assign ddr.rd       = active && copy && cnt != '0 && !have && !pend && ddr.ready;
    assign ddr.addr     = src;
    assign job.done     = active && cnt == '0;
    assign job.end_addr = ram_addr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active <= 1'b0;
            pend   <= 1'b0;
            have   <= 1'b0;
            copy   <= 1'b0;
            cnt    <= '0;
        end else if (job.start && !active) begin
            active <= 1'b1;
            pend   <= 1'b0;
            have   <= 1'b0;
            copy   <= job.req.copy;
            cnt    <= {job.req.size, {page_log2{1'b0}}};   // Pages to bytes
        end else if (job.done) begin
            active <= 1'b0;
        end else begin
            if (ddr.rd) begin
                pend <= 1'b1;
            end else if (pend && ddr.ready) begin
                pend <= 1'b0;
                have <= 1'b1;
            end
            if (ram_we) begin
                cnt  <= cnt - 1'b1;
                have <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (job.start && !active) begin
            base     <= job.req.ram_base;
            ram_addr <= job.req.ram_base;
            src      <= job.req.ddr_addr;
            pattern  <= job.req.pattern;
        end else begin
            if (ram_we) begin
                ram_addr <= ram_addr + 1'b1;
            end
            if (pend && ddr.ready) begin
                src <= src + 1'b1;
            end
        end
    end

endmodule

// File: source/config_sequencer.sv
`timescale 1ns/10ps

module config_sequencer (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         ioctl_download,
    input  logic                  [15:0] ioctl_index,
    input  upload_ctrl_pkg::load_size_t  ioctl_addr,
    input  logic                         reload,
    ddr_rd_if.client                     ddr,
    block_job_if.sequencer               job,
    layout_wr_if.sequencer               wr,
    output logic                         busy,
    output logic                         done,
    output upload_ctrl_pkg::upload_err_t error,
    output logic                         msx2
);
    import upload_ctrl_pkg::*;
    import msx_cfg_pkg::*;

    typedef enum logic [2:0] {
        s_idle,
        s_clear,
        s_read,
        s_header,
        s_record,
        s_load,
        s_layout
    } state_t;

    state_t      state;
    state_t      next;
    logic        dl_last;
    logic        trig;
    load_size_t  stream_size;
    ddr_addr_t   rd_addr;
    ram_addr_t   ram_addr;
    logic        pend;
    logic [2:0]  byte_cnt;
    logic [47:0] rec_buf;
    conf_rec_t   rec;
    logic [3:0]  ram_ref;
    logic [1:0]  blk;
    logic [1:0]  cnt;
    logic [1:0]  offset;
    logic        mem_blk;
    logic        rom_blk;
    logic        at_end;
    logic [5:0]  lay_idx;
    logic [5:0]  shadow [64];   // Ref and offset as last written

    assign rec     = conf_rec_t'(rec_buf);
    assign trig    = (dl_last && !ioctl_download && ioctl_index == 16'd1) || reload;
    assign mem_blk = rec.kind == blk_ram || rec.kind == blk_rom;
    assign rom_blk = rec.kind == blk_rom;
    assign at_end  = rd_addr >= conf_base + ddr_addr_t'(stream_size);
    assign lay_idx = {rec.slot, rec.subslot, blk};
    assign busy    = state != s_idle;

    assign ddr.rd   = state == s_read && !pend && ddr.ready && !at_end;
    assign ddr.addr = rd_addr;

    assign wr.clear      = state == s_clear;
    assign wr.look_we    = state == s_record && rec.rec_kind == rec_block && mem_blk;
    assign wr.look_idx   = ram_ref;
    assign wr.look_entry = '{base: ram_addr, size: rec.size, ro: rom_blk};
    assign wr.lay_we     = state == s_layout;
    assign wr.lay_idx    = lay_idx;
    assign wr.lay_entry  = '{
        ram_ref: mem_blk ? ram_ref : shadow[lay_idx][5:2],
        offset:  mem_blk ? offset : shadow[lay_idx][1:0],
        mapper:  mem_blk ? map_offset : mapper_t'(rec.size[2:0])
    };
    assign wr.exp_set  = state == s_layout && rec.subslot != 2'd0;
    assign wr.exp_slot = rec.slot;

    assign job.start = wr.look_we;
    assign job.req   = '{
        ram_base: ram_addr,
        ddr_addr: rd_addr,
        size:     rec.size,
        pattern:  rom_blk ? pat_ddr : pattern_t'(rec.pattern[2:0]),
        copy:     rom_blk
    };

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dl_last     <= 1'b0;
            stream_size <= '0;
        end else begin
            dl_last <= ioctl_download;
            if (dl_last && !ioctl_download && ioctl_index == 16'd1) begin
                stream_size <= ioctl_addr;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= s_idle;
            next     <= s_idle;
            done     <= 1'b0;
            error    <= err_none;
            msx2     <= 1'b0;
            pend     <= 1'b0;
            byte_cnt <= '0;
            rec_buf  <= '0;
            rd_addr  <= conf_base;
            ram_addr <= '0;
            ram_ref  <= '0;
            blk      <= '0;
            cnt      <= '0;
            offset   <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                s_idle: begin
                    if (trig) begin
                        error <= err_none;
                        state <= s_clear;
                    end
                end
                s_clear: begin
                    rd_addr  <= conf_base;
                    ram_addr <= '0;
                    ram_ref  <= '0;
                    pend     <= 1'b0;
                    byte_cnt <= '0;
                    next     <= s_header;
                    state    <= s_read;
                end
                s_read: begin
                    if (ddr.rd) begin
                        pend <= 1'b1;
                    end else if (pend && ddr.ready) begin
                        pend     <= 1'b0;
                        rec_buf  <= {ddr.dout, rec_buf[47:8]};   // Shift in from the top
                        rd_addr  <= rd_addr + 1'b1;
                        byte_cnt <= (byte_cnt == 3'd5) ? 3'd0 : byte_cnt + 3'd1;
                        if (byte_cnt == 3'd5) begin
                            state <= next;
                        end
                    end else if (!pend && ddr.ready && at_end) begin
                        done  <= 1'b1;      // Stream exhausted
                        state <= s_idle;
                    end
                end
                s_header: begin
                    if ({rec_buf[7:0], rec_buf[15:8], rec_buf[23:16]} == header_magic) begin
                        msx2  <= rec_buf[24];
                        next  <= s_record;
                        state <= s_read;
                    end else begin
                        error <= err_bad_header;
                        done  <= 1'b1;
                        state <= s_idle;
                    end
                end
                s_record: begin
                    blk    <= rec.block;
                    cnt    <= rec.count;
                    offset <= '0;
                    case (rec.rec_kind)
                        rec_block: begin
                            case (rec.kind)
                                blk_ram, blk_rom: state <= s_load;
                                blk_mapper:       state <= s_layout;
                                default: begin
                                    error <= err_bad_block;
                                    done  <= 1'b1;
                                    state <= s_idle;
                                end
                            endcase
                        end
                        rec_end: begin
                            done  <= 1'b1;
                            state <= s_idle;
                        end
                        default: begin
                            error <= err_bad_record;
                            done  <= 1'b1;
                            state <= s_idle;
                        end
                    endcase
                end
                s_load: begin
                    if (job.done) begin
                        ram_addr <= job.end_addr;
                        if (rom_blk) begin
                            rd_addr <= rd_addr + ddr_addr_t'({rec.size, {page_log2{1'b0}}});
                        end
                        state <= s_layout;
                    end
                end
                s_layout: begin
                    blk    <= blk + 2'd1;
                    offset <= offset + 2'd1;
                    cnt    <= cnt - 2'd1;
                    if (cnt == 2'd0) begin
                        if (mem_blk) begin
                            ram_ref <= ram_ref + 4'd1;
                        end
                        next  <= s_record;
                        state <= s_read;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Mapper records keep what earlier blocks wrote
    always_ff @(posedge clk) begin
        if (state == s_clear) begin
            for (int i = 0; i < 64; i++) begin
                shadow[i] <= {4'd0, 2'(i)};
            end
        end else if (state == s_layout && mem_blk) begin
            shadow[lay_idx] <= {ram_ref, offset};
        end
    end

endmodule

// File: source/ddr_arbiter.sv
`timescale 1ns/10ps

module ddr_arbiter (
    input  logic     clk,
    input  logic     arst_n,
    ddr_rd_if.memory seq,
    ddr_rd_if.memory ldr,
    ddr_rd_if.client mem
);

    typedef enum logic [1:0] {
        own_none,
        own_seq,
        own_ldr
    } owner_t;

    owner_t owner;
    logic   use_ldr;

    // Sequencer wins a same-cycle request
    assign use_ldr = owner == own_ldr || (owner == own_none && !seq.rd);

    assign mem.rd   = seq.rd || ldr.rd;
    assign mem.addr = use_ldr ? ldr.addr : seq.addr;

    assign seq.ready = mem.ready && (owner == own_seq || owner == own_none);
    assign ldr.ready = mem.ready && use_ldr;
    assign seq.dout  = mem.dout;
    assign ldr.dout  = mem.dout;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            owner <= own_none;
        end else if (seq.rd) begin
            owner <= own_seq;
        end else if (ldr.rd) begin
            owner <= own_ldr;
        end else if (owner != own_none && mem.ready) begin
            owner <= own_none;      // Read completed
        end
    end

endmodule

// File: source/layout_table.sv
`timescale 1ns/10ps

module layout_table (
    input  logic                       clk,
    input  logic                       arst_n,
    layout_wr_if.tbl                   wr,
    input  logic                 [5:0] layout_sel,
    output msx_cfg_pkg::layout_entry_t layout_out,
    input  logic                 [3:0] lookup_sel,
    output msx_cfg_pkg::lookup_entry_t lookup_out,
    output logic                 [3:0] expander_en
);
    import msx_cfg_pkg::*;

    layout_entry_t lay_mem [64];    // Indexed by slot, subslot, block
    lookup_entry_t look_mem [16];

    always_ff @(posedge clk) begin
        if (wr.clear) begin
            for (int i = 0; i < 64; i++) begin
                lay_mem[i] <= '{ram_ref: 4'd0, offset: 2'(i), mapper: map_none};
            end
        end else if (wr.lay_we) begin
            lay_mem[wr.lay_idx] <= wr.lay_entry;
        end
        if (wr.look_we) begin
            look_mem[wr.look_idx] <= wr.look_entry;
        end
        layout_out <= lay_mem[layout_sel];
        lookup_out <= look_mem[lookup_sel];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            expander_en <= '0;
        end else if (wr.clear) begin
            expander_en <= '0;
        end else if (wr.exp_set) begin
            expander_en[wr.exp_slot] <= 1'b1;
        end
    end

endmodule

// File: source/mem_upload_top.sv
`timescale 1ns/10ps

module mem_upload_top (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         ioctl_download,
    input  logic                  [15:0] ioctl_index,
    input  upload_ctrl_pkg::load_size_t  ioctl_addr,
    input  logic                         reload,
    output upload_ctrl_pkg::ddr_addr_t   ddr_addr,
    output logic                         ddr_rd,
    input  logic                   [7:0] ddr_dout,
    input  logic                         ddr_ready,
    output upload_ctrl_pkg::ram_addr_t   ram_addr,
    output logic                   [7:0] ram_din,
    output logic                         ram_we,
    input  logic                         ram_ready,
    output logic                         busy,
    output logic                         done,
    output upload_ctrl_pkg::upload_err_t error,
    output logic                         msx2,
    input  logic                   [5:0] layout_sel,
    output msx_cfg_pkg::layout_entry_t   layout_out,
    input  logic                   [3:0] lookup_sel,
    output msx_cfg_pkg::lookup_entry_t   lookup_out,
    output logic                   [3:0] expander_en
);

    ddr_rd_if    seq_ddr ();
    ddr_rd_if    ldr_ddr ();
    ddr_rd_if    mem_ddr ();
    block_job_if job ();
    layout_wr_if lay_wr ();

    assign ddr_addr      = mem_ddr.addr;
    assign ddr_rd        = mem_ddr.rd;
    assign mem_ddr.dout  = ddr_dout;
    assign mem_ddr.ready = ddr_ready;

    config_sequencer config_sequencer_i (
        .clk(clk), .arst_n(arst_n),
        .ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
        .ioctl_addr(ioctl_addr), .reload(reload),
        .ddr(seq_ddr), .job(job), .wr(lay_wr),
        .busy(busy), .done(done), .error(error), .msx2(msx2)
    );

    block_loader block_loader_i (
        .clk(clk), .arst_n(arst_n), .job(job), .ddr(ldr_ddr),
        .ram_addr(ram_addr), .ram_din(ram_din), .ram_we(ram_we), .ram_ready(ram_ready)
    );

    ddr_arbiter ddr_arbiter_i (
        .clk(clk), .arst_n(arst_n), .seq(seq_ddr), .ldr(ldr_ddr), .mem(mem_ddr)
    );

    layout_table layout_table_i (
        .clk(clk), .arst_n(arst_n), .wr(lay_wr),
        .layout_sel(layout_sel), .layout_out(layout_out),
        .lookup_sel(lookup_sel), .lookup_out(lookup_out),
        .expander_en(expander_en)
    );

endmodule

// File: source/msx_cfg_pkg.sv
package msx_cfg_pkg;

    typedef enum logic [7:0] {
        rec_block = 8'd0,
        rec_end   = 8'd2
    } rec_kind_t;

    typedef enum logic [7:0] {
        blk_ram    = 8'd0,
        blk_rom    = 8'd1,
        blk_mapper = 8'd3
    } block_kind_t;

    typedef enum logic [2:0] {
        pat_ddr,
        pat_ff,
        pat_zero,
        pat_03,
        pat_04,
        pat_05
    } pattern_t;

    typedef enum logic [2:0] {
        map_none   = 3'd0,
        map_offset = 3'd1
    } mapper_t;

    // Byte 0 sits in the low bits
    typedef struct packed {
        logic [7:0]  unused;
        logic [7:0]  pattern;
        logic [7:0]  size;          // Pages, or mapper code
        block_kind_t kind;
        logic [1:0]  slot;
        logic [1:0]  subslot;
        logic [1:0]  block;
        logic [1:0]  count;         // Block count minus one
        rec_kind_t   rec_kind;
    } conf_rec_t;

    typedef struct packed {
        logic [3:0] ram_ref;
        logic [1:0] offset;
        mapper_t    mapper;
    } layout_entry_t;

    typedef struct packed {
        upload_ctrl_pkg::ram_addr_t base;
        logic [7:0]                 size;
        logic                       ro;
    } lookup_entry_t;

    typedef struct packed {
        upload_ctrl_pkg::ram_addr_t ram_base;
        upload_ctrl_pkg::ddr_addr_t ddr_addr;   // Stream position for copies
        logic [7:0]                 size;
        pattern_t                   pattern;
        logic                       copy;
    } block_req_t;

    localparam logic [23:0] header_magic = "MSx";

endpackage

// File: source/upload_ctrl_pkg.sv
package upload_ctrl_pkg;

    typedef logic [27:0] ddr_addr_t;    // DDR byte address
    typedef logic [26:0] ram_addr_t;    // External RAM byte address
    typedef logic [26:0] load_size_t;   // Downloaded byte count

    localparam int page_log2 = 4;       // 16 byte pages

    localparam ddr_addr_t conf_base = '0;   // Start of the config stream

    typedef enum logic [1:0] {
        err_none,
        err_bad_header,
        err_bad_record,
        err_bad_block
    } upload_err_t;

endpackage

// File: source/upload_ifs.sv
`timescale 1ns/10ps

interface ddr_rd_if;
    import upload_ctrl_pkg::*;

    logic       rd;
    ddr_addr_t  addr;
    logic       ready;
    logic [7:0] dout;

    modport client (output rd, output addr, input ready, input dout);
    modport memory (input rd, input addr, output ready, output dout);
endinterface

interface block_job_if;
    import upload_ctrl_pkg::*;
    import msx_cfg_pkg::*;

    logic       start;
    block_req_t req;
    logic       done;
    ram_addr_t  end_addr;   // First RAM byte after the block

    modport sequencer (output start, output req, input done, input end_addr);
    modport loader (input start, input req, output done, output end_addr);
endinterface

interface layout_wr_if;
    import msx_cfg_pkg::*;

    logic          clear;
    logic          lay_we;
    logic [5:0]    lay_idx;
    layout_entry_t lay_entry;
    logic          look_we;
    logic [3:0]    look_idx;
    lookup_entry_t look_entry;
    logic          exp_set;
    logic [1:0]    exp_slot;

    modport sequencer (
        output clear, output lay_we, output lay_idx, output lay_entry,
        output look_we, output look_idx, output look_entry,
        output exp_set, output exp_slot
    );
    modport tbl (
        input clear, input lay_we, input lay_idx, input lay_entry,
        input look_we, input look_idx, input look_entry,
        input exp_set, input exp_slot
    );
endinterface

// File: testbench/mem_upload_asserts.sv
`timescale 1ns/10ps

module mem_upload_asserts (
    input logic clk,
    input logic arst_n,
    input logic rd,
    input logic ready,
    input logic req,
    input logic req_ready
);

    // DDR read request is a single cycle pulse
    rd_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) rd |=> !rd)
        else $error("DDR rd held longer than one cycle");

    rd_when_ready: assert property (@(posedge clk) disable iff (!arst_n) rd |-> ready)
        else $error("DDR rd issued while ready low");

    req_when_ready: assert property (@(posedge clk) disable iff (!arst_n) req |-> req_ready)
        else $error("Request issued while its ready was low");

endmodule

bind ddr_arbiter mem_upload_asserts arb_asserts_i (
    .clk(clk), .arst_n(arst_n), .rd(mem.rd), .ready(mem.ready),
    .req(seq.rd), .req_ready(seq.ready)
);

bind block_loader mem_upload_asserts ldr_asserts_i (
    .clk(clk), .arst_n(arst_n), .rd(ddr.rd), .ready(ddr.ready),
    .req(ram_we), .req_ready(ram_ready)
);

// File: testbench/tb_mem_upload.sv
`timescale 1ns/10ps

module tb_mem_upload;
    import upload_ctrl_pkg::*;
    import msx_cfg_pkg::*;

    logic          clk = 1'b0;
    logic          arst_n;
    logic          ioctl_download;
    logic [15:0]   ioctl_index;
    load_size_t    ioctl_addr;
    logic          reload;
    ddr_addr_t     ddr_addr;
    logic          ddr_rd;
    logic [7:0]    ddr_dout = 8'h00;
    logic          ddr_ready = 1'b1;
    ram_addr_t     ram_addr;
    logic [7:0]    ram_din;
    logic          ram_we;
    logic          ram_ready = 1'b1;
    logic          busy;
    logic          done;
    upload_err_t   error;
    logic          msx2;
    logic [5:0]    layout_sel;
    layout_entry_t layout_out;
    logic [3:0]    lookup_sel;
    lookup_entry_t lookup_out;
    logic [3:0]    expander_en;

    logic [7:0]    ddr_mem [4096];
    logic [7:0]    ram_mem [4096];
    logic [7:0]    saved_ram [80];
    lookup_entry_t saved_look [5];
    layout_entry_t saved_lay [5];
    logic [31:0]   rng = 32'd91;
    logic          random_delays = 1'b0;
    logic [2:0]    ddr_wait = 3'd0;
    ddr_addr_t     ddr_req_addr = '0;
    int            ram_writes = 0;
    int            wp;

    mem_upload_top mem_upload_top_i (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // DDR and RAM models
    always @(posedge clk) begin
        rng = xorshift(rng);
        ram_ready <= random_delays ? rng[8] : 1'b1;
        if (ram_we) begin
            ram_mem[ram_addr[11:0]] <= ram_din;
            ram_writes <= ram_writes + 1;
        end
        if (ddr_rd) begin
            ddr_ready    <= 1'b0;
            ddr_wait     <= random_delays ? 3'd1 + 3'(rng[1:0]) : 3'd1;
            ddr_req_addr <= ddr_addr;
        end else if (!ddr_ready) begin
            if (ddr_wait <= 3'd1) begin
                ddr_ready <= 1'b1;
                ddr_dout  <= ddr_mem[ddr_req_addr[11:0]];
            end else begin
                ddr_wait <= ddr_wait - 3'd1;
            end
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string msg);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s got %h expected %h", $time, msg, got, exp));
        end
    endtask

    task automatic check_layout(input layout_entry_t got, input layout_entry_t exp,
                                input string msg);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s got %h expected %h", $time, msg, got, exp));
        end
    endtask

    task automatic check_lookup(input lookup_entry_t got, input lookup_entry_t exp,
                                input string msg);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s got %h expected %h", $time, msg, got, exp));
        end
    endtask

    task automatic check_error(input upload_err_t got, input upload_err_t exp, input string msg);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s got %s expected %s",
                                     $time, msg, got.name(), exp.name()));
        end
    endtask

    // Expected fill byte at position p inside a block
    function automatic logic [7:0] pattern_byte(input pattern_t pat, input logic [8:0] p);
        case (pat)
            pat_ff:  return 8'hff;
            pat_03:  return (p[8] != p[1]) ? 8'hff : 8'h00;
            pat_04:  return (p[8] == p[0]) ? 8'hff : 8'h00;
            pat_05:  return p[7] ? 8'hff : 8'h00;
            default: return 8'h00;
        endcase
    endfunction

    task automatic put_byte(input logic [7:0] b);
        ddr_mem[wp] = b;
        wp++;
    endtask

    task automatic put_header(input logic [7:0] m2, input logic [7:0] magic2);
        wp = 0;
        put_byte("M");
        put_byte("S");
        put_byte(magic2);
        put_byte(m2);
        put_byte(8'h00);
        put_byte(8'h00);
    endtask

    task automatic put_record(input logic [7:0] rk, input logic [7:0] pos, input logic [7:0] bk,
                              input logic [7:0] size, input logic [7:0] pat);
        put_byte(rk);
        put_byte(pos);
        put_byte(bk);
        put_byte(size);
        put_byte(pat);
        put_byte(8'h00);
    endtask

    task automatic wait_done();
        do @(posedge clk); while (!done);
        check_byte(8'(busy), 8'd0, "busy with done");
    endtask

    task automatic run_download();
        @(posedge clk);
        ioctl_download <= 1'b1;
        ioctl_index    <= 16'd1;
        ioctl_addr     <= load_size_t'(wp);
        @(posedge clk);
        ioctl_download <= 1'b0;
        wait_done();
    endtask

    task automatic read_layout(input int idx, output layout_entry_t e);
        @(posedge clk);
        layout_sel <= 6'(idx);
        repeat (2) @(posedge clk);
        e = layout_out;
    endtask

    task automatic read_lookup(input int idx, output lookup_entry_t e);
        @(posedge clk);
        lookup_sel <= 4'(idx);
        repeat (2) @(posedge clk);
        e = lookup_out;
    endtask

    task automatic build_fill_stream(input logic [7:0] m2);
        put_header(m2, "x");
        for (int i = 0; i < 5; i++) begin
            put_record(rec_block, 8'(i << 2), blk_ram, 8'd1, 8'(i + 1));
        end
        put_record(rec_end, 8'h00, 8'h00, 8'h00, 8'h00);
    endtask

    task automatic test_pattern_fills();
        lookup_entry_t e;
        build_fill_stream(8'h01);
        run_download();
        check_error(error, err_none, "fill error code");
        check_byte(8'(msx2), 8'd1, "fill msx2");
        for (int i = 0; i < 5; i++) begin
            for (int p = 0; p < 16; p++) begin
                check_byte(ram_mem[16 * i + p], pattern_byte(pattern_t'(i + 1), 9'(p)),
                           $sformatf("fill block %0d byte %0d", i, p));
            end
            read_lookup(i, e);
            check_lookup(e, '{base: ram_addr_t'(16 * i), size: 8'd1, ro: 1'b0}, "fill lookup");
            saved_look[i] = e;
            read_layout(i, saved_lay[i]);
            check_layout(saved_lay[i], '{ram_ref: 4'(i), offset: 2'd0, mapper: map_offset},
                         "fill layout");
        end
        check_byte(8'(expander_en), 8'h01, "fill expander bits");   // Last block uses subslot 1
        for (int a = 0; a < 80; a++) begin
            saved_ram[a] = ram_mem[a];
        end
    endtask

    task automatic test_reload_backpressure();
        lookup_entry_t e;
        layout_entry_t l;
        for (int a = 0; a < 4096; a++) begin
            ram_mem[a] = 8'(a ^ (a >> 8) ^ 8'h5a);     // Scrub RAM
        end
        build_fill_stream(8'h00);
        random_delays = 1'b1;
        @(posedge clk);
        reload <= 1'b1;
        @(posedge clk);
        reload <= 1'b0;
        wait_done();
        random_delays = 1'b0;
        check_error(error, err_none, "reload error code");
        check_byte(8'(msx2), 8'd0, "reload msx2");
        check_byte(8'(expander_en), 8'h01, "reload expander bits");
        for (int a = 0; a < 80; a++) begin
            check_byte(ram_mem[a], saved_ram[a], $sformatf("reload RAM byte %0d", a));
        end
        for (int i = 0; i < 5; i++) begin
            read_lookup(i, e);
            check_lookup(e, saved_look[i], "reload lookup");
            read_layout(i, l);
            check_layout(l, saved_lay[i], "reload layout");
        end
    endtask

    task automatic test_rom_copy();
        lookup_entry_t e;
        put_header(8'h00, "x");
        put_record(rec_block, 8'h40, blk_rom, 8'd2, 8'h00);
        for (int i = 0; i < 32; i++) begin
            put_byte(8'(37 * i + 11));
        end
        put_record(rec_block, 8'h44, blk_ram, 8'd1, pat_ff);
        put_record(rec_end, 8'h00, 8'h00, 8'h00, 8'h00);
        run_download();
        check_error(error, err_none, "ROM error code");
        for (int i = 0; i < 32; i++) begin
            check_byte(ram_mem[i], 8'(37 * i + 11), $sformatf("ROM byte %0d", i));
        end
        for (int i = 32; i < 48; i++) begin
            check_byte(ram_mem[i], 8'hff, "RAM after ROM");
        end
        read_lookup(0, e);
        check_lookup(e, '{base: ram_addr_t'(0), size: 8'd2, ro: 1'b1}, "ROM lookup");
        read_lookup(1, e);
        check_lookup(e, '{base: ram_addr_t'(32), size: 8'd1, ro: 1'b0}, "lookup after ROM");
    endtask

    task automatic test_layout_expander();
        layout_entry_t l;
        put_header(8'h01, "x");
        put_record(rec_block, 8'h96, blk_ram, 8'd1, pat_zero);     // Slot 2 sub 1 blocks 1..3
        put_record(rec_block, 8'h99, blk_mapper, 8'd5, 8'h00);     // Blocks 2..3
        put_record(rec_end, 8'h00, 8'h00, 8'h00, 8'h00);
        run_download();
        check_error(error, err_none, "layout error code");
        check_byte(8'(expander_en), 8'h04, "expander bits");
        read_layout(37, l);
        check_layout(l, '{ram_ref: 4'd0, offset: 2'd0, mapper: map_offset}, "layout 37");
        read_layout(38, l);
        check_layout(l, '{ram_ref: 4'd0, offset: 2'd1, mapper: mapper_t'(3'd5)}, "layout 38");
        read_layout(39, l);
        check_layout(l, '{ram_ref: 4'd0, offset: 2'd2, mapper: mapper_t'(3'd5)}, "layout 39");
        read_layout(10, l);
        check_layout(l, '{ram_ref: 4'd0, offset: 2'd2, mapper: map_none}, "layout 10");
        read_layout(40, l);
        check_layout(l, '{ram_ref: 4'd0, offset: 2'd0, mapper: map_none}, "layout 40");
    endtask

    task automatic test_errors();
        int writes_before;
        put_header(8'h00, "y");
        put_record(rec_block, 8'h00, blk_ram, 8'd1, pat_ff);
        put_record(rec_end, 8'h00, 8'h00, 8'h00, 8'h00);
        writes_before = ram_writes;
        run_download();
        check_error(error, err_bad_header, "bad header");
        check_byte(8'(ram_writes - writes_before), 8'd0, "RAM writes on bad header");
        check_byte(8'(msx2), 8'd1, "msx2 after bad header");
        put_header(8'h00, "x");
        put_record(rec_block, 8'h00, 8'h07, 8'd1, pat_ff);
        put_record(rec_end, 8'h00, 8'h00, 8'h00, 8'h00);
        run_download();
        check_error(error, err_bad_block, "bad block kind");
    endtask

    // About 2000 DDR reads at 5 cycles each, doubled
    initial begin
        #200000;
        report_failure("Timeout: the run did not finish in time");
    end

    initial begin
        arst_n         = 1'b0;
        ioctl_download = 1'b0;
        ioctl_index    = 16'd0;
        ioctl_addr     = '0;
        reload         = 1'b0;
        layout_sel     = '0;
        lookup_sel     = '0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check_byte({busy, done, ddr_rd, ram_we}, 8'h00, "outputs after reset");
        check_error(error, err_none, "error after reset");
        test_pattern_fills();
        test_reload_backpressure();
        test_rom_copy();
        test_layout_expander();
        test_errors();
        $display("All checks passed");
        $finish;
    end

endmodule
